/* hw/loader_macros.svh */
// File loader constants
// Memory map, download indices, cartridge header offsets and the
// memory slot timing shared by the loader blocks

`ifndef LOADER_MACROS_SVH
`define LOADER_MACROS_SVH

// ============================================================
// Memory map
// ============================================================
`define LD_CRT_BASE       25'h100000
`define LD_TAP_BASE       25'h200000

// Host download indices
`define LD_IDX_PRG        8'd4
`define LD_IDX_CRT        8'd5
`define LD_IDX_CRT_ALT    8'hC0
`define LD_IDX_TAP        8'd6

// ============================================================
// Cartridge file layout
// ============================================================
`define LD_CRT_HDR_END    25'h40
`define LD_CRT_ID_OFS     25'h16
`define LD_CRT_EXROM_OFS  25'h18
`define LD_CRT_GAME_OFS   25'h19
// Chip packets start on 8 KB boundaries
`define LD_ALIGN_BITS     13

// Memory cycle of 16 slots, loader owns slot 11
`define LD_SLOT_PERIOD    16
`define LD_SLOT_INDEX     11

`endif

/* hw/loader_pkg.sv */
// Loader types
// Address, data and cartridge field types used across the file loader,
// plus the file kind decoded from the host download index

package loader_pkg;

	// Byte address into the shared memory
	typedef logic [24:0] mem_addr_t;

	// One data byte
	typedef logic [7:0] byte_t;

	// 16-bit cartridge header field
	typedef logic [15:0] word_t;

	// Remaining length of a chip packet
	typedef logic [31:0] blk_len_t;

	// Position inside a 16-byte chip packet header
	typedef logic [3:0] hdr_cnt_t;

	// Kind of file being downloaded
	typedef enum logic [1:0] {
		FK_NONE,
		FK_PRG,
		FK_CRT,
		FK_TAP
	} file_kind_e;

endpackage

/* hw/write_req_if.sv */
// Memory write request channel
// Carries one byte write from the download decoder to the slot writer
// with a valid/ready handshake

interface write_req_if
	import loader_pkg::*;
();

	logic      valid;
	logic      ready;
	mem_addr_t addr;
	byte_t     data;

	// Decoder side
	modport producer (
		output valid, addr, data,
		input  ready
	);

	// Slot writer side
	modport consumer (
		input  valid, addr, data,
		output ready
	);

endinterface

/* hw/crt_header_parser.sv */
// Cartridge header parser
// Captures the cartridge id, EXROM and GAME from the file header, walks
// each chip packet header, reports bank info and classifies every byte
// as header, alignment point or payload

`include "loader_macros.svh"

module crt_header_parser
	import loader_pkg::*;
(
	input  logic      clk_sys,
	input  logic      reset_n,
	input  logic      byte_wr_i,
	input  mem_addr_t file_ofs_i,
	input  byte_t     byte_i,
	input  mem_addr_t load_addr_i,
	output logic      payload_o,
	output logic      align_o,
	output word_t     cart_id_o,
	output byte_t     cart_exrom_o,
	output byte_t     cart_game_o,
	output logic      bank_wr_o,
	output byte_t     bank_type_o,
	output word_t     bank_num_o,
	output word_t     bank_laddr_o,
	output word_t     bank_size_o,
	output mem_addr_t bank_addr_o
);

	hdr_cnt_t hdr_cnt;
	blk_len_t blk_len;
	logic     in_pkt;
	logic     pkt_start;

	// ============================================================
	// Byte classification
	// ============================================================
	assign in_pkt    = file_ofs_i >= `LD_CRT_HDR_END;
	assign pkt_start = in_pkt && (blk_len == '0) && (hdr_cnt == '0);
	assign align_o   = byte_wr_i && pkt_start && (load_addr_i[`LD_ALIGN_BITS-1:0] != '0);
	assign payload_o = byte_wr_i && in_pkt && (hdr_cnt == '0) && (blk_len != '0);

	// Packet walk
	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			hdr_cnt   <= '0;
			blk_len   <= '0;
			bank_wr_o <= 1'b0;
		end else begin
			bank_wr_o <= 1'b0;
			if (byte_wr_i) begin
				if (file_ofs_i == '0) begin
					hdr_cnt <= '0;
					blk_len <= '0;
				end else if (pkt_start) begin
					hdr_cnt <= 4'd1;
				end else if (in_pkt && hdr_cnt != '0) begin
					// Wraps to zero after byte 15
					hdr_cnt <= hdr_cnt + 4'd1;
					case (hdr_cnt)
						4'd4: blk_len[31:24] <= byte_i;
						4'd5: blk_len[23:16] <= byte_i;
						4'd6: blk_len[15:8]  <= byte_i;
						4'd7: blk_len[7:0]   <= byte_i;
						// Packet length includes its own header
						4'd8: blk_len <= blk_len - 32'd16;
						4'd15: bank_wr_o <= 1'b1;
						default: ;
					endcase
				end else if (payload_o) begin
					blk_len <= blk_len - 32'd1;
				end
			end
		end
	end

	// ============================================================
	// Header fields
	// ============================================================
	always_ff @(posedge clk_sys) begin
		if (byte_wr_i) begin
			if (file_ofs_i == `LD_CRT_ID_OFS)         cart_id_o[15:8] <= byte_i;
			if (file_ofs_i == `LD_CRT_ID_OFS + 25'd1) cart_id_o[7:0]  <= byte_i;
			if (file_ofs_i == `LD_CRT_EXROM_OFS)      cart_exrom_o    <= byte_i;
			if (file_ofs_i == `LD_CRT_GAME_OFS)       cart_game_o     <= byte_i;
			if (in_pkt && !pkt_start) begin
				case (hdr_cnt)
					4'd9:  bank_type_o        <= byte_i;
					4'd10: bank_num_o[15:8]   <= byte_i;
					4'd11: bank_num_o[7:0]    <= byte_i;
					4'd12: bank_laddr_o[15:8] <= byte_i;
					4'd13: bank_laddr_o[7:0]  <= byte_i;
					4'd14: bank_size_o[15:8]  <= byte_i;
					4'd15: begin
						bank_size_o[7:0] <= byte_i;
						// Address was aligned at the packet's first byte
						bank_addr_o      <= load_addr_i;
					end
					default: ;
				endcase
			end
		end
	end

endmodule

/* hw/download_decoder.sv */
// Download decoder
// Decodes the file kind from the download index, tracks the load address
// for program, cartridge and tape files and turns each payload byte into
// a memory write request

`include "loader_macros.svh"

module download_decoder
	import loader_pkg::*;
(
	input  logic      clk_sys,
	input  logic      reset_n,
	input  logic      ioctl_download_i,
	input  byte_t     ioctl_index_i,
	input  logic      ioctl_wr_i,
	input  mem_addr_t ioctl_addr_i,
	input  byte_t     ioctl_data_i,
	write_req_if.producer req,
	output logic      cart_attached_o,
	output word_t     cart_id_o,
	output byte_t     cart_exrom_o,
	output byte_t     cart_game_o,
	output logic      bank_wr_o,
	output byte_t     bank_type_o,
	output word_t     bank_num_o,
	output word_t     bank_laddr_o,
	output word_t     bank_size_o,
	output mem_addr_t bank_addr_o
);

	localparam mem_addr_t ALIGN_MASK = mem_addr_t'((1 << `LD_ALIGN_BITS) - 1);

	file_kind_e kind;
	mem_addr_t  load_addr;
	mem_addr_t  cur_addr;
	logic       byte_acc;
	logic       is_payload;
	logic       crt_payload;
	logic       crt_align;
	logic       download_d;

	always_comb begin
		case (ioctl_index_i)
			`LD_IDX_PRG:                 kind = FK_PRG;
			`LD_IDX_CRT, `LD_IDX_CRT_ALT: kind = FK_CRT;
			`LD_IDX_TAP:                 kind = FK_TAP;
			default:                     kind = FK_NONE;
		endcase
	end

	assign byte_acc = ioctl_download_i && ioctl_wr_i && (kind != FK_NONE);

	// Base address takes effect on the first byte of a file
	always_comb begin
		cur_addr = load_addr;
		if (ioctl_addr_i == '0) begin
			if (kind == FK_CRT) cur_addr = `LD_CRT_BASE;
			if (kind == FK_TAP) cur_addr = `LD_TAP_BASE;
		end
	end

	always_comb begin
		case (kind)
			FK_PRG:  is_payload = ioctl_addr_i >= 25'd2;
			FK_CRT:  is_payload = crt_payload;
			FK_TAP:  is_payload = 1'b1;
			default: is_payload = 1'b0;
		endcase
	end

	// ============================================================
	// Load address and request handshake
	// ============================================================
	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			req.valid       <= 1'b0;
			load_addr       <= '0;
			download_d      <= 1'b0;
			cart_attached_o <= 1'b0;
		end else begin
			download_d <= ioctl_download_i;
			if (req.valid && req.ready) req.valid <= 1'b0;
			if (byte_acc) begin
				if (kind == FK_PRG && ioctl_addr_i == 25'd0) begin
					// Program load address, low byte first
					load_addr <= mem_addr_t'(ioctl_data_i);
				end else if (kind == FK_PRG && ioctl_addr_i == 25'd1) begin
					load_addr[15:8] <= ioctl_data_i;
				end else if (crt_align) begin
					load_addr <= (load_addr | ALIGN_MASK) + 25'd1;
				end else if (is_payload) begin
					req.valid <= 1'b1;
					load_addr <= cur_addr + 25'd1;
				end else begin
					load_addr <= cur_addr;
				end
			end
			// Attached once a cartridge download completes
			if (download_d != ioctl_download_i && kind == FK_CRT)
				cart_attached_o <= download_d;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (byte_acc && is_payload) begin
			req.addr <= cur_addr;
			req.data <= ioctl_data_i;
		end
	end

	crt_header_parser u_crt_header_parser (
		.clk_sys      (clk_sys),
		.reset_n      (reset_n),
		.byte_wr_i    (byte_acc && kind == FK_CRT),
		.file_ofs_i   (ioctl_addr_i),
		.byte_i       (ioctl_data_i),
		.load_addr_i  (load_addr),
		.payload_o    (crt_payload),
		.align_o      (crt_align),
		.cart_id_o    (cart_id_o),
		.cart_exrom_o (cart_exrom_o),
		.cart_game_o  (cart_game_o),
		.bank_wr_o    (bank_wr_o),
		.bank_type_o  (bank_type_o),
		.bank_num_o   (bank_num_o),
		.bank_laddr_o (bank_laddr_o),
		.bank_size_o  (bank_size_o),
		.bank_addr_o  (bank_addr_o)
	);

endmodule

/* hw/slot_writer.sv */
// Memory slot writer
// Holds one write request and issues it to the shared memory only in
// the loader's slot of the memory cycle

`include "loader_macros.svh"

module slot_writer
	import loader_pkg::*;
(
	input  logic      clk_sys,
	input  logic      reset_n,
	write_req_if.consumer req,
	output logic      mem_ce_o,
	output logic      mem_we_o,
	output mem_addr_t mem_addr_o,
	output byte_t     mem_data_o
);

	localparam int SLOT_W = $clog2(`LD_SLOT_PERIOD);

	logic [SLOT_W-1:0] slot_cnt;
	logic              held;
	logic              slot_hit;
	mem_addr_t         addr_q;
	byte_t             data_q;

	// ============================================================
	// Slot counter, free running over one memory cycle
	// ============================================================
	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			slot_cnt <= '0;
		end else if (slot_cnt == SLOT_W'(`LD_SLOT_PERIOD - 1)) begin
			slot_cnt <= '0;
		end else begin
			slot_cnt <= slot_cnt + 1'b1;
		end
	end

	assign slot_hit  = slot_cnt == SLOT_W'(`LD_SLOT_INDEX);
	assign req.ready = !held;

	// One-entry request register
	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			held <= 1'b0;
		end else if (req.valid && req.ready) begin
			held <= 1'b1;
		end else if (held && slot_hit) begin
			held <= 1'b0;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (req.valid && req.ready) begin
			addr_q <= req.addr;
			data_q <= req.data;
		end
	end

	// Write strobe lasts exactly the loader's slot
	assign mem_ce_o   = held && slot_hit;
	assign mem_we_o   = held && slot_hit;
	assign mem_addr_o = addr_q;
	assign mem_data_o = data_q;

endmodule

/* hw/c64_loader_top.sv */
// File loader top level
// Connects the host download port to the decoder and the slot writer
// and brings the memory write port and cartridge info out as plain ports

module c64_loader_top
	import loader_pkg::*;
(
	input  logic      clk_sys,
	input  logic      reset_n,

	// Host download port
	input  logic      ioctl_download_i,
	input  byte_t     ioctl_index_i,
	input  logic      ioctl_wr_i,
	input  mem_addr_t ioctl_addr_i,
	input  byte_t     ioctl_data_i,
	output logic      ioctl_wait_o,

	// Shared memory write port
	output logic      mem_ce_o,
	output logic      mem_we_o,
	output mem_addr_t mem_addr_o,
	output byte_t     mem_data_o,

	// Cartridge info
	output logic      cart_attached_o,
	output word_t     cart_id_o,
	output byte_t     cart_exrom_o,
	output byte_t     cart_game_o,

	// Chip packet bank info
	output logic      bank_wr_o,
	output byte_t     bank_type_o,
	output word_t     bank_num_o,
	output word_t     bank_laddr_o,
	output word_t     bank_size_o,
	output mem_addr_t bank_addr_o
);

	write_req_if wr_req ();

	// Host waits while a request sits in the channel or in the slot writer
	assign ioctl_wait_o = wr_req.valid || !wr_req.ready;

	download_decoder u_download_decoder (
		.clk_sys          (clk_sys),
		.reset_n          (reset_n),
		.ioctl_download_i (ioctl_download_i),
		.ioctl_index_i    (ioctl_index_i),
		.ioctl_wr_i       (ioctl_wr_i),
		.ioctl_addr_i     (ioctl_addr_i),
		.ioctl_data_i     (ioctl_data_i),
		.req              (wr_req.producer),
		.cart_attached_o  (cart_attached_o),
		.cart_id_o        (cart_id_o),
		.cart_exrom_o     (cart_exrom_o),
		.cart_game_o      (cart_game_o),
		.bank_wr_o        (bank_wr_o),
		.bank_type_o      (bank_type_o),
		.bank_num_o       (bank_num_o),
		.bank_laddr_o     (bank_laddr_o),
		.bank_size_o      (bank_size_o),
		.bank_addr_o      (bank_addr_o)
	);

	slot_writer u_slot_writer (
		.clk_sys    (clk_sys),
		.reset_n    (reset_n),
		.req        (wr_req.consumer),
		.mem_ce_o   (mem_ce_o),
		.mem_we_o   (mem_we_o),
		.mem_addr_o (mem_addr_o),
		.mem_data_o (mem_data_o)
	);

endmodule

/* tb/tb_c64_loader_sva.sv */
// File loader protocol checks
// Concurrent assertions on the host handshake and the memory write
// port, bound into the loader top level

module tb_c64_loader_sva (
	input logic clk_sys,
	input logic reset_n,
	input logic ioctl_wr_i,
	input logic ioctl_wait_o,
	input logic mem_ce_o,
	input logic mem_we_o
);

	timeunit 1ns;
	timeprecision 1ps;

	// Every write strobe comes with a chip enable
	we_implies_ce: assert property (
		@(posedge clk_sys) disable iff (!reset_n)
		mem_we_o |-> mem_ce_o
	) else $error("mem_we_o high without mem_ce_o");

	// No pending request right out of reset
	wait_low_after_reset: assert property (
		@(posedge clk_sys)
		$rose(reset_n) |-> !ioctl_wait_o
	) else $error("ioctl_wait_o high in the first cycle after reset");

	// Host must hold off while the loader is busy
	no_wr_during_wait: assert property (
		@(posedge clk_sys) disable iff (!reset_n)
		ioctl_wr_i |-> !ioctl_wait_o
	) else $error("ioctl_wr_i pulsed while ioctl_wait_o was high");

endmodule

bind c64_loader_top tb_c64_loader_sva u_loader_sva (
	.clk_sys      (clk_sys),
	.reset_n      (reset_n),
	.ioctl_wr_i   (ioctl_wr_i),
	.ioctl_wait_o (ioctl_wait_o),
	.mem_ce_o     (mem_ce_o),
	.mem_we_o     (mem_we_o)
);

/* tb/tb_c64_loader.sv */
// File loader testbench
// Directed program, cartridge and tape downloads against a memory model
// on the write port and a reference model of the load addresses

`include "loader_macros.svh"

module tb_c64_loader
	import loader_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int TOTAL_BYTES = 42 + 64 + 140 + 32 + 64;
	// Each byte costs at most one memory cycle plus the handshake
	localparam int CYCLE_LIMIT = TOTAL_BYTES * (`LD_SLOT_PERIOD + 8) + 200;
	localparam mem_addr_t ALIGN_MASK = 25'h1FFF;

	logic      clk_sys;
	logic      reset_n;
	logic      ioctl_download_i;
	byte_t     ioctl_index_i;
	logic      ioctl_wr_i;
	mem_addr_t ioctl_addr_i;
	byte_t     ioctl_data_i;
	logic      ioctl_wait_o;
	logic      mem_ce_o;
	logic      mem_we_o;
	mem_addr_t mem_addr_o;
	byte_t     mem_data_o;
	logic      cart_attached_o;
	word_t     cart_id_o;
	byte_t     cart_exrom_o;
	byte_t     cart_game_o;
	logic      bank_wr_o;
	byte_t     bank_type_o;
	word_t     bank_num_o;
	word_t     bank_laddr_o;
	word_t     bank_size_o;
	mem_addr_t bank_addr_o;

	// Memory model, write log and expected writes
	byte_t       mem [mem_addr_t];
	mem_addr_t   wr_addr_q [$];
	byte_t       wr_data_q [$];
	mem_addr_t   exp_addr_q [$];
	byte_t       exp_data_q [$];
	// Bank records as {type, num, laddr, size, addr}
	logic [80:0] bank_q [$];
	logic [80:0] exp_bank_q [$];

	int          write_cnt;
	int          run_cycles;
	int          wait_cycles;
	int          value_errs;
	int          other_errs;
	logic [31:0] rng_state;

	c64_loader_top UUT (.*);

	initial clk_sys = 1'b0;
	always #4 clk_sys = ~clk_sys;

	// ============================================================
	// Monitors and helpers
	// ============================================================
	always @(negedge clk_sys) begin
		if (mem_we_o) begin
			if (!mem_ce_o) report_failure("mem_we_o high without mem_ce_o");
			if (run_cycles % `LD_SLOT_PERIOD != `LD_SLOT_INDEX)
				report_failure($sformatf("memory write in slot %0d instead of the loader slot",
					run_cycles % `LD_SLOT_PERIOD));
			mem[mem_addr_o] = mem_data_o;
			wr_addr_q.push_back(mem_addr_o);
			wr_data_q.push_back(mem_data_o);
			write_cnt++;
		end
		if (bank_wr_o)
			bank_q.push_back({bank_type_o, bank_num_o, bank_laddr_o, bank_size_o, bank_addr_o});
		// Cycles since reset, slot 0 is the first cycle out of reset
		if (!reset_n)
			run_cycles = 0;
		else
			run_cycles++;
	end

	task automatic report_mismatch(input string name, input logic [31:0] exp_v,
		input logic [31:0] got_v);
		$display("FAIL t=%0t %s expected=%0h got=%0h", $time, name, exp_v, got_v);
		value_errs++;
	endtask

	task automatic report_failure(input string what);
		$display("ERROR t=%0t %s", $time, what);
		other_errs++;
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic byte_t rand_byte();
		rng_state = xorshift32(rng_state);
		return rng_state[7:0];
	endfunction

	task automatic clear_logs();
		mem.delete();
		wr_addr_q.delete();
		wr_data_q.delete();
		exp_addr_q.delete();
		exp_data_q.delete();
		bank_q.delete();
		exp_bank_q.delete();
	endtask

	task automatic start_download(input byte_t index);
		@(posedge clk_sys);
		ioctl_download_i <= 1'b1;
		ioctl_index_i    <= index;
	endtask

	// Index stays put so the loader sees which file ended
	task automatic end_download();
		@(posedge clk_sys);
		ioctl_download_i <= 1'b0;
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
	endtask

	// One host byte, then hold off while the loader asks to wait
	task automatic send_byte(input mem_addr_t ofs, input byte_t data, input bit payload);
		int   writes_before;
		logic seen_we;
		writes_before = write_cnt;
		wait_cycles   = 0;
		seen_we       = 1'b0;
		@(posedge clk_sys);
		ioctl_wr_i   <= 1'b1;
		ioctl_addr_i <= ofs;
		ioctl_data_i <= data;
		@(posedge clk_sys);
		ioctl_wr_i <= 1'b0;
		@(negedge clk_sys);
		if (ioctl_wait_o !== payload)
			report_mismatch("ioctl_wait_o", payload, ioctl_wait_o);
		while (ioctl_wait_o) begin
			// Wait must drop in the cycle after the memory write
			if (seen_we) begin
				report_failure("ioctl_wait_o stayed high after the memory write");
				seen_we = 1'b0;
			end else begin
				seen_we = mem_we_o;
			end
			wait_cycles++;
			@(negedge clk_sys);
		end
		if (write_cnt != writes_before + int'(payload))
			report_failure($sformatf("byte at offset %0h caused %0d memory writes",
				ofs, write_cnt - writes_before));
	endtask

	task automatic send_payload(input mem_addr_t ofs, input mem_addr_t addr, input byte_t data);
		exp_addr_q.push_back(addr);
		exp_data_q.push_back(data);
		send_byte(ofs, data, 1'b1);
	endtask

	task automatic check_writes();
		if (wr_addr_q.size() != exp_addr_q.size())
			report_failure($sformatf("saw %0d memory writes, expected %0d",
				wr_addr_q.size(), exp_addr_q.size()));
		foreach (exp_addr_q[i]) begin
			if (i < wr_addr_q.size()) begin
				if (wr_addr_q[i] != exp_addr_q[i])
					report_mismatch("mem_addr_o", exp_addr_q[i], wr_addr_q[i]);
				if (wr_data_q[i] != exp_data_q[i])
					report_mismatch("mem_data_o", exp_data_q[i], wr_data_q[i]);
			end
			if (!mem.exists(exp_addr_q[i]))
				report_failure($sformatf("memory byte %0h was never written", exp_addr_q[i]));
		end
	endtask

	task automatic check_banks();
		logic [80:0] got_b;
		logic [80:0] exp_b;
		if (bank_q.size() != exp_bank_q.size())
			report_failure($sformatf("saw %0d bank_wr_o pulses, expected %0d",
				bank_q.size(), exp_bank_q.size()));
		foreach (exp_bank_q[i]) begin
			if (i < bank_q.size()) begin
				got_b = bank_q[i];
				exp_b = exp_bank_q[i];
				if (got_b[80:73] != exp_b[80:73])
					report_mismatch("bank_type_o", exp_b[80:73], got_b[80:73]);
				if (got_b[72:57] != exp_b[72:57])
					report_mismatch("bank_num_o", exp_b[72:57], got_b[72:57]);
				if (got_b[56:41] != exp_b[56:41])
					report_mismatch("bank_laddr_o", exp_b[56:41], got_b[56:41]);
				if (got_b[40:25] != exp_b[40:25])
					report_mismatch("bank_size_o", exp_b[40:25], got_b[40:25]);
				if (got_b[24:0] != exp_b[24:0])
					report_mismatch("bank_addr_o", exp_b[24:0], got_b[24:0]);
			end
		end
	endtask

	// ============================================================
	// Cartridge file builders
	// ============================================================
	task automatic send_crt_header(output word_t id, output byte_t exrom, output byte_t game);
		byte_t b;
		id    = {rand_byte(), rand_byte()};
		exrom = rand_byte();
		game  = rand_byte();
		for (int ofs = 0; ofs < `LD_CRT_HDR_END; ofs++) begin
			case (ofs)
				`LD_CRT_ID_OFS:          b = id[15:8];
				`LD_CRT_ID_OFS + 1:      b = id[7:0];
				`LD_CRT_EXROM_OFS:       b = exrom;
				`LD_CRT_GAME_OFS:        b = game;
				default:                 b = rand_byte();
			endcase
			send_byte(mem_addr_t'(ofs), b, 1'b0);
		end
	endtask

	task automatic send_chip_packet(inout mem_addr_t ofs, inout mem_addr_t load,
		input byte_t ctype, input word_t bank, input word_t laddr, input int len);
		byte_t       hdr [16];
		logic [31:0] pkt_len;
		word_t       size;
		pkt_len = 32'(len + 16);
		size    = word_t'(len);
		// Payload starts on the next 8 KB boundary
		load = (load + ALIGN_MASK) & ~ALIGN_MASK;
		hdr = '{8'h43, 8'h48, 8'h49, 8'h50,
			pkt_len[31:24], pkt_len[23:16], pkt_len[15:8], pkt_len[7:0],
			8'h00, ctype, bank[15:8], bank[7:0],
			laddr[15:8], laddr[7:0], size[15:8], size[7:0]};
		exp_bank_q.push_back({ctype, bank, laddr, size, load});
		for (int i = 0; i < 16; i++) begin
			send_byte(ofs, hdr[i], 1'b0);
			ofs++;
		end
		for (int i = 0; i < len; i++) begin
			send_payload(ofs, load, rand_byte());
			ofs++;
			load++;
		end
	endtask

	// ============================================================
	// Directed tests
	// ============================================================
	task automatic test_prg();
		mem_addr_t load;
		load = 25'h0801;
		clear_logs();
		start_download(`LD_IDX_PRG);
		send_byte(25'd0, load[7:0], 1'b0);
		send_byte(25'd1, load[15:8], 1'b0);
		for (int i = 0; i < 40; i++) begin
			send_payload(mem_addr_t'(i + 2), load + mem_addr_t'(i), rand_byte());
		end
		end_download();
		check_writes();
		if (mem.exists(25'd0) || mem.exists(25'd1) || mem.num() != 40)
			report_failure("program download wrote outside its payload range");
	endtask

	task automatic test_crt_header();
		word_t id;
		byte_t exrom;
		byte_t game;
		clear_logs();
		start_download(`LD_IDX_CRT);
		send_crt_header(id, exrom, game);
		if (cart_id_o !== id) report_mismatch("cart_id_o", id, cart_id_o);
		if (cart_exrom_o !== exrom) report_mismatch("cart_exrom_o", exrom, cart_exrom_o);
		if (cart_game_o !== game) report_mismatch("cart_game_o", game, cart_game_o);
		end_download();
		if (cart_attached_o !== 1'b1) report_mismatch("cart_attached_o", 1, cart_attached_o);
		if (wr_addr_q.size() != 0) report_failure("cartridge file header reached memory");
	endtask

	task automatic test_crt_banks();
		mem_addr_t ofs;
		mem_addr_t load;
		word_t     id;
		byte_t     exrom;
		byte_t     game;
		clear_logs();
		ofs  = `LD_CRT_HDR_END;
		load = `LD_CRT_BASE;
		start_download(`LD_IDX_CRT_ALT);
		send_crt_header(id, exrom, game);
		send_chip_packet(ofs, load, 8'h00, 16'h0000, 16'h8000, 24);
		send_chip_packet(ofs, load, 8'h02, 16'h0001, 16'hA000, 20);
		end_download();
		check_writes();
		check_banks();
		if (cart_attached_o !== 1'b1) report_mismatch("cart_attached_o", 1, cart_attached_o);
	endtask

	task automatic test_tape();
		clear_logs();
		start_download(`LD_IDX_TAP);
		for (int n = 0; n < 32; n++) begin
			send_payload(mem_addr_t'(n), `LD_TAP_BASE + mem_addr_t'(n), rand_byte());
		end
		end_download();
		check_writes();
	endtask

	task automatic test_back_pressure();
		clear_logs();
		start_download(`LD_IDX_TAP);
		for (int n = 0; n < 64; n++) begin
			send_payload(mem_addr_t'(n), `LD_TAP_BASE + mem_addr_t'(n), rand_byte());
			// Handshake plus at most one full memory cycle
			if (wait_cycles < 2 || wait_cycles > `LD_SLOT_PERIOD + 1)
				report_failure($sformatf("ioctl_wait_o stayed high for %0d cycles", wait_cycles));
		end
		end_download();
		check_writes();
	endtask

	// ============================================================
	// Main sequence and watchdog
	// ============================================================
	initial begin
		reset_n          = 1'b0;
		ioctl_download_i = 1'b0;
		ioctl_index_i    = '0;
		ioctl_wr_i       = 1'b0;
		ioctl_addr_i     = '0;
		ioctl_data_i     = '0;
		rng_state        = 32'h7a040784;
		repeat (2) @(posedge clk_sys);
		reset_n <= 1'b1;
		@(negedge clk_sys);
		if (mem_ce_o !== 1'b0) report_mismatch("mem_ce_o", 0, mem_ce_o);
		if (mem_we_o !== 1'b0) report_mismatch("mem_we_o", 0, mem_we_o);
		if (ioctl_wait_o !== 1'b0) report_mismatch("ioctl_wait_o", 0, ioctl_wait_o);
		if (bank_wr_o !== 1'b0) report_mismatch("bank_wr_o", 0, bank_wr_o);
		if (cart_attached_o !== 1'b0) report_mismatch("cart_attached_o", 0, cart_attached_o);
		test_prg();
		test_crt_header();
		test_crt_banks();
		test_tape();
		test_back_pressure();
		$display("Value errors: %0d, other errors: %0d, memory writes: %0d",
			value_errs, other_errs, write_cnt);
		if (value_errs + other_errs == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

	initial begin : watchdog
		int cycle_cnt;
		cycle_cnt = 0;
		while (cycle_cnt < CYCLE_LIMIT) begin
			@(posedge clk_sys);
			cycle_cnt++;
		end
		$display("Timeout after %0d cycles, value errors: %0d, other errors: %0d",
			CYCLE_LIMIT, value_errs, other_errs);
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

/* list.f */
+incdir+hw
hw/loader_pkg.sv
hw/write_req_if.sv
hw/crt_header_parser.sv
hw/download_decoder.sv
hw/slot_writer.sv
hw/c64_loader_top.sv
tb/tb_c64_loader_sva.sv
tb/tb_c64_loader.sv

/* Makefile */
# Verilator build for the file loader testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
TOP       = tb_c64_loader
FILELIST  = list.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then \
		echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "TEST RESULT: PASS" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
